// ==== tx_config.svh ====
// sizes and AXI4-Lite register map of the DAC transmit chain
// included by the package and by every module that sizes per-channel arrays
`ifndef TX_CONFIG_SVH
`define TX_CONFIG_SVH

`define TX_CHANNELS       2
`define TX_CH_BITS        1
`define TX_SAMPLE_WIDTH   16
`define TX_PHASE_BITS     32
`define TX_AWG_DEPTH      64
`define TX_AWG_ADDR_BITS  6
// scale is signed Q2.14
`define TX_SCALE_FRAC     14

// register map, byte addresses of 32-bit words
`define TX_ADDR_CTRL          12'h000
`define TX_ADDR_SELECT        12'h004
`define TX_ADDR_TRIG          12'h008
`define TX_ADDR_FRAME         12'h00C
`define TX_ADDR_PHASE_INC     12'h010
`define TX_ADDR_SCALE_OFFSET  12'h020
// AWG window, channel in offset bit 8, sample index in offset bits 7:2
`define TX_AWG_BASE           12'h100

`endif

// ==== tx_pkg.sv ====
// shared data types of the transmit chain
// every module takes them with a wildcard import
`include "tx_config.svh"

package tx_pkg;

  typedef logic signed [`TX_SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [`TX_PHASE_BITS-1:0] phase_t;

  // gain in Q2.14
  typedef logic signed [15:0] scale_t;
  typedef logic signed [15:0] offset_t;

  typedef logic [`TX_AWG_ADDR_BITS-1:0] awg_addr_t;

  // also used as trigger source code
  typedef enum logic [1:0] {
    src_zero = 2'd0,
    src_saw  = 2'd1,
    src_tri  = 2'd2,
    src_awg  = 2'd3
  } source_sel_t;

endpackage

// ==== tx_regs.sv ====
// AXI4-Lite slave with the control and per-channel configuration registers
// AWG window writes leave as one-cycle memory write pulses
`timescale 1ns/1ps
`include "tx_config.svh"

module tx_regs import tx_pkg::*; (
  input  logic ps_clk,
  input  logic ps_reset,
  input  logic [11:0] awaddr,
  input  logic awvalid,
  output logic awready,
  input  logic [31:0] wdata,
  input  logic [3:0] wstrb,
  input  logic wvalid,
  output logic wready,
  output logic bvalid,
  output logic [1:0] bresp,
  input  logic bready,
  input  logic [11:0] araddr,
  input  logic arvalid,
  output logic arready,
  output logic rvalid,
  output logic [31:0] rdata,
  output logic [1:0] rresp,
  input  logic rready,
  output logic enable,
  output source_sel_t select [`TX_CHANNELS],
  output source_sel_t trig_source,
  output logic [`TX_CH_BITS-1:0] trig_channel,
  output awg_addr_t frame_last,
  output phase_t phase_inc [`TX_CHANNELS],
  output scale_t scale [`TX_CHANNELS],
  output offset_t offset [`TX_CHANNELS],
  output logic awg_we,
  output logic [`TX_CH_BITS-1:0] awg_channel,
  output awg_addr_t awg_addr,
  output sample_t awg_data
);

  localparam logic [11:0] AWG_SPAN = 12'(`TX_CHANNELS * `TX_AWG_DEPTH * 4);

  logic wr_fire;
  logic rd_fire;
  logic [11:0] wr_word;
  logic [11:0] wr_off;
  logic wr_in_awg;
  logic [31:0] wr_old;
  logic [31:0] wr_val;
  logic [31:0] rd_val;

  // every access answers OKAY
  assign bresp = 2'b00;
  assign rresp = 2'b00;

  assign wr_fire = awready && awvalid;
  assign rd_fire = arready && arvalid;
  assign wr_word = {awaddr[11:2], 2'b00};
  assign wr_off = awaddr - `TX_AWG_BASE;
  assign wr_in_awg = (awaddr >= `TX_AWG_BASE) && (wr_off < AWG_SPAN);

  // stored value of a register, zero for the AWG window and holes
  function automatic logic [31:0] reg_value(input logic [11:0] addr);
    logic [11:0] wa;
    logic [31:0] v;
    wa = {addr[11:2], 2'b00};
    v = '0;
    case (wa)
      `TX_ADDR_CTRL: v[0] = enable;
      `TX_ADDR_TRIG: begin
        v[1:0] = trig_source;
        v[4 +: `TX_CH_BITS] = trig_channel;
      end
      `TX_ADDR_FRAME: v[`TX_AWG_ADDR_BITS-1:0] = frame_last;
      default: v = '0;
    endcase
    for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
      if (wa == `TX_ADDR_SELECT) begin
        v[2*ch +: 2] = select[ch];
      end
      if (wa == `TX_ADDR_PHASE_INC + 12'(4*ch)) begin
        v = phase_inc[ch];
      end
      if (wa == `TX_ADDR_SCALE_OFFSET + 12'(4*ch)) begin
        v = {scale[ch], offset[ch]};
      end
    end
    return v;
  endfunction

  function automatic logic [31:0] merge_strb(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] strb);
    logic [31:0] v;
    for (int b = 0; b < 4; b++) begin
      v[8*b +: 8] = strb[b] ? data[8*b +: 8] : old[8*b +: 8];
    end
    return v;
  endfunction

  always_comb begin
    wr_old = reg_value(awaddr);
    wr_val = merge_strb(wr_old, wdata, wstrb);
    rd_val = reg_value(araddr);
  end

  // handshakes, one write and one read in flight at most
  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      awready <= 1'b0;
      wready <= 1'b0;
      bvalid <= 1'b0;
      arready <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      awready <= !awready && !bvalid && awvalid && wvalid;
      wready <= !awready && !bvalid && awvalid && wvalid;
      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      arready <= !arready && !rvalid && arvalid;
      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      enable <= 1'b0;
      trig_source <= src_zero;
      trig_channel <= '0;
      frame_last <= '0;
      awg_we <= 1'b0;
      for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
        select[ch] <= src_zero;
        phase_inc[ch] <= '0;
        scale[ch] <= '0;
        offset[ch] <= '0;
      end
    end else begin
      awg_we <= wr_fire && wr_in_awg;
      if (wr_fire) begin
        case (wr_word)
          `TX_ADDR_CTRL: enable <= wr_val[0];
          `TX_ADDR_TRIG: begin
            trig_source <= source_sel_t'(wr_val[1:0]);
            trig_channel <= wr_val[4 +: `TX_CH_BITS];
          end
          `TX_ADDR_FRAME: frame_last <= wr_val[`TX_AWG_ADDR_BITS-1:0];
          default: ;
        endcase
        for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
          if (wr_word == `TX_ADDR_SELECT) begin
            select[ch] <= source_sel_t'(wr_val[2*ch +: 2]);
          end
          if (wr_word == `TX_ADDR_PHASE_INC + 12'(4*ch)) begin
            phase_inc[ch] <= wr_val;
          end
          if (wr_word == `TX_ADDR_SCALE_OFFSET + 12'(4*ch)) begin
            scale[ch] <= wr_val[31:16];
            offset[ch] <= wr_val[15:0];
          end
        end
      end
    end
  end

  always_ff @(posedge ps_clk) begin
    if (wr_fire) begin
      awg_channel <= wr_off[2 + `TX_AWG_ADDR_BITS +: `TX_CH_BITS];
      awg_addr <= wr_off[2 +: `TX_AWG_ADDR_BITS];
      awg_data <= wdata[`TX_SAMPLE_WIDTH-1:0];
    end
    if (rd_fire) begin
      rdata <= rd_val;
    end
  end

endmodule

// ==== tx_phase_gen.sv ====
// source stage, one phase accumulator per channel
// emits sawtooth, folded triangle and a wrap flag every enabled cycle
`timescale 1ns/1ps
`include "tx_config.svh"

module tx_phase_gen import tx_pkg::*; (
  input  logic ps_clk,
  input  logic ps_reset,
  input  logic enable,
  input  phase_t phase_inc [`TX_CHANNELS],
  output sample_t saw [`TX_CHANNELS],
  output sample_t tri_wave [`TX_CHANNELS],
  output logic wrap [`TX_CHANNELS],
  output logic src_valid
);

  localparam int PB = `TX_PHASE_BITS;
  localparam int SW = `TX_SAMPLE_WIDTH;

  phase_t phase [`TX_CHANNELS];
  phase_t phase_sum [`TX_CHANNELS];
  logic carry [`TX_CHANNELS];
  // set when the phase about to be emitted came from a wrap
  logic wrap_next [`TX_CHANNELS];
  sample_t tri_now [`TX_CHANNELS];

  always_comb begin
    for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
      {carry[ch], phase_sum[ch]} = {1'b0, phase[ch]} + {1'b0, phase_inc[ch]};
      // fold below msb, ramp up in first half, down in second
      if (phase[ch][PB-1]) begin
        tri_now[ch] = sample_t'({1'b0, {(SW-1){1'b1}}} - phase[ch][PB-2 -: SW]);
      end else begin
        tri_now[ch] = sample_t'(phase[ch][PB-2 -: SW] - {1'b1, {(SW-1){1'b0}}});
      end
    end
  end

  always_ff @(posedge ps_clk) begin
    if (ps_reset || !enable) begin
      src_valid <= 1'b0;
      for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
        phase[ch] <= '0;
        wrap_next[ch] <= 1'b1;
        wrap[ch] <= 1'b0;
      end
    end else begin
      src_valid <= 1'b1;
      for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
        phase[ch] <= phase_sum[ch];
        wrap_next[ch] <= carry[ch];
        wrap[ch] <= wrap_next[ch];
      end
    end
  end

  always_ff @(posedge ps_clk) begin
    if (enable) begin
      for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
        saw[ch] <= phase[ch][PB-1 -: SW];
        tri_wave[ch] <= tri_now[ch];
      end
    end
  end

endmodule

// ==== tx_awg.sv ====
// source stage, arbitrary waveform player with one sample memory per channel
// a shared index walks 0..frame_last, reads registered to line up with the phase path
`timescale 1ns/1ps
`include "tx_config.svh"

module tx_awg import tx_pkg::*; (
  input  logic ps_clk,
  input  logic ps_reset,
  input  logic enable,
  input  awg_addr_t frame_last,
  input  logic awg_we,
  input  logic [`TX_CH_BITS-1:0] awg_channel,
  input  awg_addr_t awg_addr,
  input  sample_t awg_data,
  output sample_t awg_sample [`TX_CHANNELS],
  output logic frame_start
);

  sample_t mem [`TX_CHANNELS][`TX_AWG_DEPTH];
  awg_addr_t rd_idx;

  // memory writes from the register file, playback reads
  always_ff @(posedge ps_clk) begin
    for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
      if (awg_we && (awg_channel == `TX_CH_BITS'(ch))) begin
        mem[ch][awg_addr] <= awg_data;
      end
      if (enable) begin
        awg_sample[ch] <= mem[ch][rd_idx];
      end
    end
  end

  // index held at zero while disabled so playback restarts at the frame top
  always_ff @(posedge ps_clk) begin
    if (ps_reset || !enable) begin
      rd_idx <= '0;
      frame_start <= 1'b0;
    end else begin
      frame_start <= (rd_idx == '0);
      if (rd_idx == frame_last) begin
        rd_idx <= '0;
      end else begin
        rd_idx <= rd_idx + 1'b1;
      end
    end
  end

endmodule

// ==== tx_source_select.sv ====
// select stage, registered per-channel choice of source
// also picks the trigger from one channel's wrap flag or the AWG frame start
`timescale 1ns/1ps
`include "tx_config.svh"

module tx_source_select import tx_pkg::*; (
  input  logic ps_clk,
  input  logic ps_reset,
  input  logic src_valid,
  input  source_sel_t select [`TX_CHANNELS],
  input  source_sel_t trig_source,
  input  logic [`TX_CH_BITS-1:0] trig_channel,
  input  sample_t saw [`TX_CHANNELS],
  input  sample_t tri_wave [`TX_CHANNELS],
  input  logic wrap [`TX_CHANNELS],
  input  sample_t awg_sample [`TX_CHANNELS],
  input  logic frame_start,
  output sample_t sel_sample [`TX_CHANNELS],
  output logic sel_trigger,
  output logic sel_valid
);

  logic trig_now;

  always_comb begin
    case (trig_source)
      src_saw, src_tri: trig_now = wrap[trig_channel];
      src_awg: trig_now = frame_start;
      default: trig_now = 1'b0;
    endcase
  end

  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      sel_valid <= 1'b0;
      sel_trigger <= 1'b0;
    end else begin
      sel_valid <= src_valid;
      sel_trigger <= src_valid && trig_now;
    end
  end

  always_ff @(posedge ps_clk) begin
    for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
      case (select[ch])
        src_saw: sel_sample[ch] <= saw[ch];
        src_tri: sel_sample[ch] <= tri_wave[ch];
        src_awg: sel_sample[ch] <= awg_sample[ch];
        default: sel_sample[ch] <= '0;
      endcase
    end
  end

endmodule

// ==== tx_prescaler.sv ====
// prescale stage, signed Q2.14 gain and offset per channel
// result clamps to the sample range, trigger and valid travel alongside
`timescale 1ns/1ps
`include "tx_config.svh"

module tx_prescaler import tx_pkg::*; (
  input  logic ps_clk,
  input  logic ps_reset,
  input  logic sel_valid,
  input  sample_t sel_sample [`TX_CHANNELS],
  input  logic sel_trigger,
  input  scale_t scale [`TX_CHANNELS],
  input  offset_t offset [`TX_CHANNELS],
  output sample_t out_sample [`TX_CHANNELS],
  output logic out_trigger,
  output logic out_valid
);

  localparam int SW = `TX_SAMPLE_WIDTH;
  localparam logic signed [32:0] SAT_MAX = (33'sd1 <<< (SW-1)) - 33'sd1;
  localparam logic signed [32:0] SAT_MIN = -(33'sd1 <<< (SW-1));

  logic signed [31:0] product [`TX_CHANNELS];
  logic signed [32:0] shifted [`TX_CHANNELS];
  logic signed [32:0] sum [`TX_CHANNELS];
  sample_t clamped [`TX_CHANNELS];

  always_comb begin
    for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
      // full product, then drop the fraction bits
      product[ch] = sel_sample[ch] * scale[ch];
      shifted[ch] = product[ch] >>> `TX_SCALE_FRAC;
      sum[ch] = shifted[ch] + offset[ch];
      if (sum[ch] > SAT_MAX) begin
        clamped[ch] = sample_t'(SAT_MAX);
      end else if (sum[ch] < SAT_MIN) begin
        clamped[ch] = sample_t'(SAT_MIN);
      end else begin
        clamped[ch] = sum[ch][SW-1:0];
      end
    end
  end

  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      out_valid <= 1'b0;
      out_trigger <= 1'b0;
    end else begin
      out_valid <= sel_valid;
      out_trigger <= sel_valid && sel_trigger;
    end
  end

  always_ff @(posedge ps_clk) begin
    for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
      out_sample[ch] <= clamped[ch];
    end
  end

endmodule

// ==== transmit_top.sv ====
// DAC transmit chain top, register file plus the three pipeline stages
// sources, then select, then prescale; out_valid follows enable by three cycles
`timescale 1ns/1ps
`include "tx_config.svh"

module transmit_top import tx_pkg::*; (
  input  logic ps_clk,
  input  logic ps_reset,
  input  logic [11:0] awaddr,
  input  logic awvalid,
  output logic awready,
  input  logic [31:0] wdata,
  input  logic [3:0] wstrb,
  input  logic wvalid,
  output logic wready,
  output logic bvalid,
  output logic [1:0] bresp,
  input  logic bready,
  input  logic [11:0] araddr,
  input  logic arvalid,
  output logic arready,
  output logic rvalid,
  output logic [31:0] rdata,
  output logic [1:0] rresp,
  input  logic rready,
  output sample_t out_sample [`TX_CHANNELS],
  output logic out_trigger,
  output logic out_valid
);

  // configuration from the register file
  logic enable;
  source_sel_t select [`TX_CHANNELS];
  source_sel_t trig_source;
  logic [`TX_CH_BITS-1:0] trig_channel;
  awg_addr_t frame_last;
  phase_t phase_inc [`TX_CHANNELS];
  scale_t scale [`TX_CHANNELS];
  offset_t offset [`TX_CHANNELS];
  logic awg_we;
  logic [`TX_CH_BITS-1:0] awg_channel;
  awg_addr_t awg_addr;
  sample_t awg_data;

  // stage outputs
  sample_t saw [`TX_CHANNELS];
  sample_t tri_wave [`TX_CHANNELS];
  logic wrap [`TX_CHANNELS];
  logic src_valid;
  sample_t awg_sample [`TX_CHANNELS];
  logic frame_start;
  sample_t sel_sample [`TX_CHANNELS];
  logic sel_trigger;
  logic sel_valid;

  tx_regs tx_regs_i (.*);
  tx_phase_gen tx_phase_gen_i (.*);
  tx_awg tx_awg_i (.*);
  tx_source_select tx_source_select_i (.*);
  tx_prescaler tx_prescaler_i (.*);

endmodule

// ==== tx_checker.sv ====
// protocol assertions on the AXI4-Lite responses and on the sample output
// bound into transmit_top, failures raise $error and bump fail_count
`timescale 1ns/1ps

module tx_checker (
  input logic ps_clk,
  input logic ps_reset,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready,
  input logic out_valid,
  input logic out_trigger
);

  int fail_count = 0;

  // responses stay up until the master takes them
  assert property (@(posedge ps_clk) disable iff (ps_reset) bvalid && !bready |=> bvalid)
    else begin
      $error("bvalid dropped before bready");
      fail_count++;
    end

  assert property (@(posedge ps_clk) disable iff (ps_reset) rvalid && !rready |=> rvalid)
    else begin
      $error("rvalid dropped before rready");
      fail_count++;
    end

  assert property (@(posedge ps_clk) ps_reset |=> !out_valid)
    else begin
      $error("out_valid high in the cycle after reset");
      fail_count++;
    end

  // trigger only rides on a valid sample
  assert property (@(posedge ps_clk) disable iff (ps_reset) out_trigger |-> out_valid)
    else begin
      $error("out_trigger without out_valid");
      fail_count++;
    end

endmodule

bind transmit_top tx_checker tx_checker_i (
  .ps_clk      (ps_clk),
  .ps_reset    (ps_reset),
  .bvalid      (bvalid),
  .bready      (bready),
  .rvalid      (rvalid),
  .rready      (rready),
  .out_valid   (out_valid),
  .out_trigger (out_trigger)
);

// ==== tx_scoreboard.sv ====
// reference model of the transmit chain fed by snooping the AXI4-Lite bus
// compares read data and the output stream and prints one line per test and the totals
`timescale 1ns/1ps
`include "tx_config.svh"

module tx_scoreboard import tx_pkg::*; (
  input  logic ps_clk,
  input  logic ps_reset,
  input  logic [11:0] awaddr,
  input  logic awvalid,
  input  logic awready,
  input  logic [31:0] wdata,
  input  logic [3:0] wstrb,
  input  logic wready,
  input  logic bvalid,
  input  logic bready,
  input  logic [1:0] bresp,
  input  logic [11:0] araddr,
  input  logic arvalid,
  input  logic arready,
  input  logic [31:0] rdata,
  input  logic rvalid,
  input  logic rready,
  input  logic [1:0] rresp,
  input  sample_t out_sample [`TX_CHANNELS],
  input  logic out_trigger,
  input  logic out_valid,
  input  int test_id,
  input  int min_samples,
  input  logic test_end,
  input  logic report_totals,
  output int err_total
);

  // register and memory copies
  logic m_en;
  logic [1:0] m_sel [2];
  logic [1:0] m_tsrc;
  logic m_tch;
  logic [5:0] m_frame;
  logic [31:0] m_inc [2];
  logic signed [15:0] m_scl [2];
  logic signed [15:0] m_ofs [2];
  logic [15:0] m_mem [2][64];

  logic [31:0] rd_expect;
  logic [11:0] rd_addr;
  logic prev_valid;
  int k;
  int test_checks;
  int test_errors;
  int test_samples;
  int tests_done;
  int total_checks;

  function automatic string test_title(input int n);
    case (n)
      1: return "register readback";
      2: return "sawtooth and triangle";
      3: return "AWG playback";
      4: return "prescaler";
      5: return "enable restart";
      default: return "unnamed";
    endcase
  endfunction

  function automatic logic [31:0] reg_expect(input logic [11:0] addr);
    logic [11:0] w;
    w = {addr[11:2], 2'b00};
    case (w)
      `TX_ADDR_CTRL: return {31'd0, m_en};
      `TX_ADDR_SELECT: return {28'd0, m_sel[1], m_sel[0]};
      `TX_ADDR_TRIG: return {27'd0, m_tch, 2'd0, m_tsrc};
      `TX_ADDR_FRAME: return {26'd0, m_frame};
      `TX_ADDR_PHASE_INC: return m_inc[0];
      `TX_ADDR_PHASE_INC + 12'd4: return m_inc[1];
      `TX_ADDR_SCALE_OFFSET: return {m_scl[0], m_ofs[0]};
      `TX_ADDR_SCALE_OFFSET + 12'd4: return {m_scl[1], m_ofs[1]};
      default: return 32'd0;
    endcase
  endfunction

  // source sample of item n whose phase is n times the increment
  function automatic logic signed [15:0] source_sample(input int ch, input int n);
    logic [31:0] ph;
    logic [15:0] u;
    ph = 32'(n) * m_inc[ch];
    u = ph[30:15];
    case (m_sel[ch])
      2'd1: return ph[31:16];
      2'd2: return ph[31] ? 16'h7FFF - u : u - 16'h8000;
      2'd3: return m_mem[ch][n % (int'(m_frame) + 1)];
      default: return 16'h0000;
    endcase
  endfunction

  function automatic logic signed [15:0] scaled(input logic signed [15:0] s,
                                                input logic signed [15:0] g,
                                                input logic signed [15:0] o);
    longint p;
    p = (longint'(s) * longint'(g)) >>> 14;
    p = p + longint'(o);
    if (p > 32767) begin
      p = 32767;
    end else if (p < -32768) begin
      p = -32768;
    end
    return 16'(p);
  endfunction

  function automatic logic expected_trigger(input int n);
    logic [31:0] ph;
    logic [31:0] prev;
    ph = 32'(n) * m_inc[m_tch];
    prev = 32'(n - 1) * m_inc[m_tch];
    case (m_tsrc)
      2'd1, 2'd2: return (n == 0) || (ph < prev);
      2'd3: return (n % (int'(m_frame) + 1)) == 0;
      default: return 1'b0;
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, input int at);
    test_checks++;
    if (expected !== actual) begin
      test_errors++;
      $display("Fail %s expected 0x%h got 0x%h at %0d", name, expected, actual, at);
    end
  endtask

  always @(posedge ps_clk) begin : watch
    logic [11:0] off;
    logic [31:0] old;
    logic [31:0] nv;
    if (ps_reset) begin
      m_en <= 1'b0;
      m_tsrc <= 2'd0;
      m_tch <= 1'b0;
      m_frame <= '0;
      for (int ch = 0; ch < 2; ch++) begin
        m_sel[ch] <= 2'd0;
        m_inc[ch] <= '0;
        m_scl[ch] <= '0;
        m_ofs[ch] <= '0;
      end
      prev_valid <= 1'b0;
      k = 0;
      test_checks = 0;
      test_errors = 0;
      test_samples = 0;
      tests_done = 0;
      total_checks = 0;
      err_total = 0;
    end else begin
      if (awvalid && awready) begin
        // write data goes in with the address
        compare_value("wready", 32'd1, 32'(wready), 0);
        off = awaddr - `TX_AWG_BASE;
        old = reg_expect(awaddr);
        for (int b = 0; b < 4; b++) begin
          nv[8*b +: 8] = wstrb[b] ? wdata[8*b +: 8] : old[8*b +: 8];
        end
        if (awaddr >= `TX_AWG_BASE && off < 12'h200) begin
          m_mem[off[8]][off[7:2]] <= wdata[15:0];
        end else begin
          case ({awaddr[11:2], 2'b00})
            `TX_ADDR_CTRL: m_en <= nv[0];
            `TX_ADDR_SELECT: begin
              m_sel[0] <= nv[1:0];
              m_sel[1] <= nv[3:2];
            end
            `TX_ADDR_TRIG: begin
              m_tsrc <= nv[1:0];
              m_tch <= nv[4];
            end
            `TX_ADDR_FRAME: m_frame <= nv[5:0];
            `TX_ADDR_PHASE_INC: m_inc[0] <= nv;
            `TX_ADDR_PHASE_INC + 12'd4: m_inc[1] <= nv;
            `TX_ADDR_SCALE_OFFSET: begin
              m_scl[0] <= nv[31:16];
              m_ofs[0] <= nv[15:0];
            end
            `TX_ADDR_SCALE_OFFSET + 12'd4: begin
              m_scl[1] <= nv[31:16];
              m_ofs[1] <= nv[15:0];
            end
            default: ;
          endcase
        end
      end
      if (bvalid && bready) begin
        compare_value("bresp", 32'd0, 32'(bresp), 0);
      end
      if (arvalid && arready) begin
        rd_expect <= reg_expect(araddr);
        rd_addr <= araddr;
      end
      if (rvalid && rready) begin
        compare_value($sformatf("rdata@0x%h", rd_addr), rd_expect, rdata, 0);
        compare_value("rresp", 32'd0, 32'(rresp), 0);
      end
      // a gap in out_valid means the stream restarts at item 0
      if (out_valid) begin
        k = prev_valid ? k + 1 : 0;
        test_samples++;
        for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
          compare_value($sformatf("out_sample[%0d]", ch),
                        32'(scaled(source_sample(ch, k), m_scl[ch], m_ofs[ch])),
                        32'(out_sample[ch]), k);
        end
        compare_value("out_trigger", 32'(expected_trigger(k)), 32'(out_trigger), k);
      end
      prev_valid <= out_valid;
      if (test_end) begin
        if (test_samples < min_samples) begin
          test_errors++;
          $display("test %0d produced %0d output samples where at least %0d were due",
                   test_id, test_samples, min_samples);
        end
        $display("test %0d %s: %0d checks, %0d errors", test_id, test_title(test_id),
                 test_checks, test_errors);
        tests_done++;
        total_checks += test_checks;
        err_total += test_errors;
        test_checks = 0;
        test_errors = 0;
        test_samples = 0;
      end
      if (report_totals) begin
        $display("totals: %0d tests, %0d checks, %0d errors", tests_done, total_checks,
                 err_total);
      end
    end
  end

endmodule

// ==== tb_transmit_top.sv ====
// testbench for the DAC transmit chain with random AXI4-Lite setup and streaming tests
// tests run in sequence here and tx_scoreboard compares the responses
`timescale 1ns/1ps
`include "tx_config.svh"

module tb_transmit_top import tx_pkg::*; ();

  localparam int CLK_PERIOD_NS = 40;
  localparam int NUM_TESTS = 5;
  localparam int CYCLES_PER_TEST = 2000;
  localparam int MARGIN_CYCLES = 1000;
  localparam int TIMEOUT_NS = (NUM_TESTS * CYCLES_PER_TEST + MARGIN_CYCLES) * CLK_PERIOD_NS;
  localparam logic [15:0] EXTREMES [4] = '{16'h7FFF, 16'h8000, 16'h0000, 16'hFFFF};
  localparam logic [11:0] REG_ADDRS [8] = '{12'h000, 12'h004, 12'h008, 12'h00C,
                                            12'h010, 12'h014, 12'h020, 12'h024};

  logic ps_clk = 1'b0;
  logic ps_reset;
  logic [11:0] awaddr;
  logic awvalid;
  logic awready;
  logic [31:0] wdata;
  logic [3:0] wstrb;
  logic wvalid;
  logic wready;
  logic bvalid;
  logic [1:0] bresp;
  logic bready;
  logic [11:0] araddr;
  logic arvalid;
  logic arready;
  logic rvalid;
  logic [31:0] rdata;
  logic [1:0] rresp;
  logic rready;
  sample_t out_sample [`TX_CHANNELS];
  logic out_trigger;
  logic out_valid;
  int test_id;
  int min_samples;
  logic test_end;
  logic report_totals;
  int err_total;
  integer seed = 32'hb315_e420;

  transmit_top transmit_top_i (.*);
  tx_scoreboard scoreboard_i (.*);

  always #(CLK_PERIOD_NS / 2) ps_clk = ~ps_clk;

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int stall;
    stall = rand_below(3);
    @(posedge ps_clk);
    awaddr <= addr;
    wdata <= data;
    wstrb <= strb;
    awvalid <= 1'b1;
    wvalid <= 1'b1;
    do begin
      @(posedge ps_clk);
    end while (!awready);
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    // hold off bready now and then so bvalid has to wait
    repeat (stall) @(posedge ps_clk);
    bready <= 1'b1;
    do begin
      @(posedge ps_clk);
    end while (!(bvalid && bready));
    bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [11:0] addr);
    int stall;
    stall = rand_below(3);
    @(posedge ps_clk);
    araddr <= addr;
    arvalid <= 1'b1;
    do begin
      @(posedge ps_clk);
    end while (!arready);
    arvalid <= 1'b0;
    repeat (stall) @(posedge ps_clk);
    rready <= 1'b1;
    do begin
      @(posedge ps_clk);
    end while (!(rvalid && rready));
    rready <= 1'b0;
  endtask

  // enable, let n samples out, read enable back, disable and wait for the drain
  task automatic run_stream(input int n);
    axi_write(`TX_ADDR_CTRL, 32'd1, 4'hF);
    do begin
      @(posedge ps_clk);
    end while (!out_valid);
    repeat (n - 1) @(posedge ps_clk);
    axi_read(`TX_ADDR_CTRL);
    axi_write(`TX_ADDR_CTRL, 32'd0, 4'hF);
    while (out_valid) @(posedge ps_clk);
  endtask

  task automatic close_test(input int num, input int min_count);
    @(posedge ps_clk);
    test_id <= num;
    min_samples <= min_count;
    test_end <= 1'b1;
    @(posedge ps_clk);
    test_end <= 1'b0;
  endtask

  initial begin
    logic [31:0] v;
    ps_reset = 1'b1;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    test_id = 0;
    min_samples = 0;
    test_end = 1'b0;
    report_totals = 1'b0;
    repeat (16) @(posedge ps_clk);
    ps_reset <= 1'b0;

    // test 1 reads back registers written with random strobes and enable kept clear
    foreach (REG_ADDRS[i]) begin
      v = rand_word();
      if (i == 0) begin
        v[0] = 1'b0;
      end
      axi_write(REG_ADDRS[i], v, 4'(rand_word()));
    end
    foreach (REG_ADDRS[i]) begin
      axi_read(REG_ADDRS[i]);
    end
    axi_read(12'h018);
    axi_read(12'h104);
    axi_read(12'hFF0);
    close_test(1, 0);

    // test 2 plays sawtooth and triangle at unity gain
    for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
      axi_write(`TX_ADDR_PHASE_INC + 12'(4 * ch), rand_word(), 4'hF);
      axi_write(`TX_ADDR_SCALE_OFFSET + 12'(4 * ch), 32'h4000_0000, 4'hF);
    end
    v = 32'(((1 + rand_below(2)) << 2) | (1 + rand_below(2)));
    axi_write(`TX_ADDR_SELECT, v, 4'hF);
    axi_write(`TX_ADDR_TRIG, 32'((rand_below(2) << 4) | (1 + rand_below(2))), 4'hF);
    run_stream(200);
    close_test(2, 200);

    // test 3 plays the AWG over a random frame
    axi_write(`TX_ADDR_FRAME, 32'(rand_below(64)), 4'hF);
    for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
      for (int i = 0; i < `TX_AWG_DEPTH; i++) begin
        axi_write(`TX_AWG_BASE + 12'(ch * 256 + i * 4), rand_word(), 4'hF);
      end
    end
    axi_write(`TX_ADDR_SELECT, 32'hF, 4'hF);
    axi_write(`TX_ADDR_TRIG, 32'h3, 4'hF);
    run_stream(200);
    close_test(3, 200);

    // test 4 puts random and extreme gain and offset on sawtooth
    axi_write(`TX_ADDR_SELECT, 32'h5, 4'hF);
    axi_write(`TX_ADDR_TRIG, 32'h1, 4'hF);
    for (int r = 0; r < 4; r++) begin
      axi_write(`TX_ADDR_PHASE_INC, rand_word(), 4'hF);
      axi_write(`TX_ADDR_PHASE_INC + 12'd4, rand_word(), 4'hF);
      axi_write(`TX_ADDR_SCALE_OFFSET, rand_word(), 4'hF);
      v = {EXTREMES[rand_below(4)], EXTREMES[rand_below(4)]};
      axi_write(`TX_ADDR_SCALE_OFFSET + 12'd4, v, 4'hF);
      run_stream(50);
    end
    close_test(4, 200);

    // test 5 restarts twice while channel 0 on src_zero shows its offset
    axi_write(`TX_ADDR_SELECT, 32'h8, 4'hF);
    axi_write(`TX_ADDR_TRIG, 32'h12, 4'hF);
    axi_write(`TX_ADDR_SCALE_OFFSET, rand_word(), 4'hF);
    axi_write(`TX_ADDR_SCALE_OFFSET + 12'd4, 32'h4000_0000, 4'hF);
    run_stream(60);
    run_stream(60);
    close_test(5, 120);

    @(posedge ps_clk);
    report_totals <= 1'b1;
    @(posedge ps_clk);
    report_totals <= 1'b0;
    @(posedge ps_clk);
    if (err_total == 0 && transmit_top_i.tx_checker_i.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog sized from the test count
  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns before the tests completed", TIMEOUT_NS);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+.
tx_pkg.sv
tx_regs.sv
tx_phase_gen.sv
tx_awg.sv
tx_source_select.sv
tx_prescaler.sv
transmit_top.sv
tx_checker.sv
tx_scoreboard.sv
tb_transmit_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_transmit_top
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIM_ARGS ?= +verilator+error+limit+100

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) tx_config.svh $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$($(BIN) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf $(OBJ_DIR)
